// ==== include/mfp_ahb_macros.svh ====
`ifndef MFP_AHB_MACROS_SVH
`define MFP_AHB_MACROS_SVH

// Address decode, boot and GPIO compare HADDR[28:22]
`define MFP_BOOT_ADDR_MATCH      7'h7f
`define MFP_GPIO_ADDR_MATCH      7'h7e

// Main RAM compares HADDR[28] only
`define MFP_RAM_ADDR_MATCH       1'b0

// Word-address bits, 4 KB boot RAM and 16 KB main RAM
`define MFP_BOOT_RAM_ADDR_WIDTH  10
`define MFP_RAM_ADDR_WIDTH       12

// GPIO pin widths
`define MFP_N_SWITCHES           18
`define MFP_N_BUTTONS            4
`define MFP_N_RED_LEDS           18
`define MFP_N_GREEN_LEDS         9
`define MFP_7_SEGMENT_HEX_WIDTH  32

// GPIO register word offsets in HADDR[4:2]
`define MFP_GPIO_RED_LEDS        3'd0
`define MFP_GPIO_GREEN_LEDS      3'd1
`define MFP_GPIO_7_SEGMENT_HEX   3'd2
`define MFP_GPIO_SWITCHES        3'd3
`define MFP_GPIO_BUTTONS         3'd4

`endif

// ==== logic/mfp_ahb_gpio_slave.sv ====
`timescale 1ns/10ps
`include "mfp_ahb_macros.svh"

module mfp_ahb_gpio_slave (
    input  logic                                HCLK,
    input  logic                                rst,
    mfp_ahb_slave_if.target                     bus,
    input  logic [`MFP_N_SWITCHES-1:0]          io_switches,
    input  logic [`MFP_N_BUTTONS-1:0]           io_buttons,
    output logic [`MFP_N_RED_LEDS-1:0]          io_red_leds,
    output logic [`MFP_N_GREEN_LEDS-1:0]        io_green_leds,
    output logic [`MFP_7_SEGMENT_HEX_WIDTH-1:0] io_7_segment_hex
);

    logic                                accept;
    logic                                wr_en;
    logic                                wr_now;
    logic [2:0]                          wr_offset;

    logic [`MFP_N_RED_LEDS-1:0]          red_next;
    logic [`MFP_N_GREEN_LEDS-1:0]        green_next;
    logic [`MFP_7_SEGMENT_HEX_WIDTH-1:0] hex_next;

    logic [31:0]                         rd_mux;
    logic [31:0]                         rd_data;

    assign accept = bus.sel && bus.hready_in && mfp_ahb_pkg::is_active(bus.htrans);

    always_ff @(posedge HCLK) begin
        if (rst)
            wr_en <= 1'b0;
        else if (bus.hready_in)
            wr_en <= accept && bus.hwrite;
    end

    always_ff @(posedge HCLK) begin
        if (accept && bus.hwrite)
            wr_offset <= bus.haddr[4:2];
    end

    assign wr_now = wr_en && bus.hready_in;

    // ------------------------------
    // Output registers, input offsets ignore writes
    always_comb begin
        red_next   = io_red_leds;
        green_next = io_green_leds;
        hex_next   = io_7_segment_hex;
        if (wr_now) begin
            case (wr_offset)
                `MFP_GPIO_RED_LEDS:      red_next   = bus.hwdata[`MFP_N_RED_LEDS-1:0];
                `MFP_GPIO_GREEN_LEDS:    green_next = bus.hwdata[`MFP_N_GREEN_LEDS-1:0];
                `MFP_GPIO_7_SEGMENT_HEX: hex_next   = bus.hwdata[`MFP_7_SEGMENT_HEX_WIDTH-1:0];
                default:                 ;
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            io_red_leds      <= '0;
            io_green_leds    <= '0;
            io_7_segment_hex <= '0;
        end else begin
            io_red_leds      <= red_next;
            io_green_leds    <= green_next;
            io_7_segment_hex <= hex_next;
        end
    end

    // ------------------------------
    // Read mux sees a write finishing on the same edge
    always_comb begin
        rd_mux = '0;
        case (bus.haddr[4:2])
            `MFP_GPIO_RED_LEDS:      rd_mux[`MFP_N_RED_LEDS-1:0]          = red_next;
            `MFP_GPIO_GREEN_LEDS:    rd_mux[`MFP_N_GREEN_LEDS-1:0]        = green_next;
            `MFP_GPIO_7_SEGMENT_HEX: rd_mux[`MFP_7_SEGMENT_HEX_WIDTH-1:0] = hex_next;
            `MFP_GPIO_SWITCHES:      rd_mux[`MFP_N_SWITCHES-1:0]          = io_switches;
            `MFP_GPIO_BUTTONS:       rd_mux[`MFP_N_BUTTONS-1:0]           = io_buttons;
            default:                 rd_mux = '0;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (accept && !bus.hwrite)
            rd_data <= rd_mux;
    end

    assign bus.hrdata     = rd_data;
    assign bus.hready_out = 1'b1;
    assign bus.hresp      = mfp_ahb_pkg::OKAY;

endmodule

// ==== logic/mfp_ahb_lite_matrix.sv ====
`timescale 1ns/10ps
`include "mfp_ahb_macros.svh"

module mfp_ahb_lite_matrix (
    input  logic                 HCLK,
    input  logic                 rst,
    input  logic [31:0]          haddr,
    input  mfp_ahb_pkg::htrans_t htrans,
    output logic                 hready,
    output logic [31:0]          hrdata,
    output mfp_ahb_pkg::hresp_t  hresp,
    mfp_ahb_slave_if.matrix      boot_bus,
    mfp_ahb_slave_if.matrix      ram_bus,
    mfp_ahb_slave_if.matrix      gpio_bus
);

    typedef enum logic {
        DEF_READY,
        DEF_WAIT
    } def_state_t;

    mfp_ahb_pkg::target_t addr_tgt;
    mfp_ahb_pkg::target_t data_tgt;
    logic                 active;
    logic                 unmapped;

    def_state_t           def_state;
    logic                 def_err;
    logic                 def_ready;
    mfp_ahb_pkg::hresp_t  def_resp;

    assign active   = mfp_ahb_pkg::is_active(htrans);
    assign unmapped = active && (addr_tgt == mfp_ahb_pkg::TGT_NONE);

    // ------------------------------
    // Address decode, boot wins over RAM wins over GPIO
    always_comb begin
        if (haddr[28:22] == `MFP_BOOT_ADDR_MATCH)
            addr_tgt = mfp_ahb_pkg::TGT_BOOT;
        else if (haddr[28] == `MFP_RAM_ADDR_MATCH)
            addr_tgt = mfp_ahb_pkg::TGT_RAM;
        else if (haddr[28:22] == `MFP_GPIO_ADDR_MATCH)
            addr_tgt = mfp_ahb_pkg::TGT_GPIO;
        else
            addr_tgt = mfp_ahb_pkg::TGT_NONE;
    end

    assign boot_bus.sel       = (addr_tgt == mfp_ahb_pkg::TGT_BOOT);
    assign boot_bus.haddr     = haddr;
    assign boot_bus.htrans    = htrans;
    assign boot_bus.hready_in = hready;

    assign ram_bus.sel        = (addr_tgt == mfp_ahb_pkg::TGT_RAM);
    assign ram_bus.haddr      = haddr;
    assign ram_bus.htrans     = htrans;
    assign ram_bus.hready_in  = hready;

    assign gpio_bus.sel       = (addr_tgt == mfp_ahb_pkg::TGT_GPIO);
    assign gpio_bus.haddr     = haddr;
    assign gpio_bus.htrans    = htrans;
    assign gpio_bus.hready_in = hready;

    // Data-phase owner, moves only when the bus is ready
    always_ff @(posedge HCLK) begin
        if (rst) begin
            data_tgt <= mfp_ahb_pkg::TGT_NONE;
            def_err  <= 1'b0;
        end else if (hready) begin
            data_tgt <= addr_tgt;
            def_err  <= unmapped;
        end
    end

    // ------------------------------
    // Default responder, wait cycle then ready, ERROR on both
    always_ff @(posedge HCLK) begin
        if (rst)
            def_state <= DEF_READY;
        else begin
            case (def_state)
                DEF_READY:
                    if (hready && unmapped)
                        def_state <= DEF_WAIT;
                DEF_WAIT:
                    def_state <= DEF_READY;
                default:
                    def_state <= DEF_READY;
            endcase
        end
    end

    assign def_ready = (def_state == DEF_READY);
    assign def_resp  = def_err ? mfp_ahb_pkg::ERROR : mfp_ahb_pkg::OKAY;

    assign hready = boot_bus.hready_out & ram_bus.hready_out
                  & gpio_bus.hready_out & def_ready;

    // ------------------------------
    // Response mux
    always_comb begin
        case (data_tgt)
            mfp_ahb_pkg::TGT_BOOT: begin
                hrdata = boot_bus.hrdata;
                hresp  = boot_bus.hresp;
            end
            mfp_ahb_pkg::TGT_RAM: begin
                hrdata = ram_bus.hrdata;
                hresp  = ram_bus.hresp;
            end
            mfp_ahb_pkg::TGT_GPIO: begin
                hrdata = gpio_bus.hrdata;
                hresp  = gpio_bus.hresp;
            end
            default: begin
                hrdata = '0;
                hresp  = def_resp;
            end
        endcase
    end

endmodule

// ==== logic/mfp_ahb_pkg.sv ====
package mfp_ahb_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

    // Owner of the current data phase
    typedef enum logic [1:0] {
        TGT_BOOT = 2'd0,
        TGT_RAM  = 2'd1,
        TGT_GPIO = 2'd2,
        TGT_NONE = 2'd3
    } target_t;

    function automatic logic is_active(htrans_t trans);
        return (trans == NONSEQ) || (trans == SEQ);
    endfunction

endpackage

// ==== logic/mfp_ahb_ram_slave.sv ====
`timescale 1ns/10ps

module mfp_ahb_ram_slave #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic            HCLK,
    input  logic            rst,
    mfp_ahb_slave_if.target bus
);

    localparam int WORDS = 2 ** ADDR_WIDTH;

    logic [31:0]           mem [0:WORDS-1];

    logic                  accept;
    logic [ADDR_WIDTH-1:0] addr_index;
    logic [3:0]            addr_be;

    logic                  wr_en;
    logic                  wr_now;
    logic [ADDR_WIDTH-1:0] wr_index;
    logic [3:0]            wr_be;
    logic [31:0]           rd_data;

    assign accept     = bus.sel && bus.hready_in && mfp_ahb_pkg::is_active(bus.htrans);
    assign addr_index = bus.haddr[ADDR_WIDTH+1:2];

    // Little-endian byte lanes
    always_comb begin
        case (bus.hsize)
            mfp_ahb_pkg::BYTE: addr_be = 4'b0001 << bus.haddr[1:0];
            mfp_ahb_pkg::HALF: addr_be = bus.haddr[1] ? 4'b1100 : 4'b0011;
            default:           addr_be = 4'b1111;
        endcase
    end

    // ------------------------------
    // Write data phase
    always_ff @(posedge HCLK) begin
        if (rst)
            wr_en <= 1'b0;
        else if (bus.hready_in)
            wr_en <= accept && bus.hwrite;
    end

    always_ff @(posedge HCLK) begin
        if (accept && bus.hwrite) begin
            wr_index <= addr_index;
            wr_be    <= addr_be;
        end
    end

    assign wr_now = wr_en && bus.hready_in;

    always_ff @(posedge HCLK) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_now && wr_be[i])
                mem[wr_index][8*i +: 8] <= bus.hwdata[8*i +: 8];
        end
    end

    // ------------------------------
    // Read at address phase
    always_ff @(posedge HCLK) begin
        if (accept && !bus.hwrite) begin
            rd_data <= mem[addr_index];
            // Lanes written on this same edge come from the bus
            for (int i = 0; i < 4; i++) begin
                if (wr_now && wr_be[i] && (wr_index == addr_index))
                    rd_data[8*i +: 8] <= bus.hwdata[8*i +: 8];
            end
        end
    end

    assign bus.hrdata     = rd_data;
    assign bus.hready_out = 1'b1;
    assign bus.hresp      = mfp_ahb_pkg::OKAY;

endmodule

// ==== logic/mfp_ahb_slave_if.sv ====
`timescale 1ns/10ps

interface mfp_ahb_slave_if;

    // Address phase and write data, matrix side
    logic                 sel;
    logic [31:0]          haddr;
    mfp_ahb_pkg::htrans_t htrans;
    logic                 hwrite;
    mfp_ahb_pkg::hsize_t  hsize;
    logic [31:0]          hwdata;
    logic                 hready_in;

    // Response, target side
    logic [31:0]          hrdata;
    logic                 hready_out;
    mfp_ahb_pkg::hresp_t  hresp;

    modport matrix (
        output sel,
        output haddr,
        output htrans,
        output hwrite,
        output hsize,
        output hwdata,
        output hready_in,
        input  hrdata,
        input  hready_out,
        input  hresp
    );

    modport target (
        input  sel,
        input  haddr,
        input  htrans,
        input  hwrite,
        input  hsize,
        input  hwdata,
        input  hready_in,
        output hrdata,
        output hready_out,
        output hresp
    );

endinterface

// ==== logic/mfp_system.sv ====
`timescale 1ns/10ps
`include "mfp_ahb_macros.svh"

module mfp_system (
    input  logic                                HCLK,
    input  logic                                rst,
    input  logic [31:0]                         haddr,
    input  logic [31:0]                         hwdata,
    input  logic [1:0]                          htrans,
    input  logic [2:0]                          hsize,
    input  logic                                hwrite,
    output logic [31:0]                         hrdata,
    output logic                                hready,
    output logic                                hresp,
    input  logic [`MFP_N_SWITCHES-1:0]          io_switches,
    input  logic [`MFP_N_BUTTONS-1:0]           io_buttons,
    output logic [`MFP_N_RED_LEDS-1:0]          io_red_leds,
    output logic [`MFP_N_GREEN_LEDS-1:0]        io_green_leds,
    output logic [`MFP_7_SEGMENT_HEX_WIDTH-1:0] io_7_segment_hex
);

    mfp_ahb_slave_if boot_bus ();
    mfp_ahb_slave_if ram_bus ();
    mfp_ahb_slave_if gpio_bus ();

    // Write direction, size and data fan out to every target
    assign boot_bus.hwrite = hwrite;
    assign boot_bus.hsize  = mfp_ahb_pkg::hsize_t'(hsize);
    assign boot_bus.hwdata = hwdata;
    assign ram_bus.hwrite  = hwrite;
    assign ram_bus.hsize   = mfp_ahb_pkg::hsize_t'(hsize);
    assign ram_bus.hwdata  = hwdata;
    assign gpio_bus.hwrite = hwrite;
    assign gpio_bus.hsize  = mfp_ahb_pkg::hsize_t'(hsize);
    assign gpio_bus.hwdata = hwdata;

    mfp_ahb_lite_matrix matrix (
        .HCLK     ( HCLK                               ),
        .rst      ( rst                                ),
        .haddr    ( haddr                              ),
        .htrans   ( mfp_ahb_pkg::htrans_t'(htrans)     ),
        .hready   ( hready                             ),
        .hrdata   ( hrdata                             ),
        .hresp    ( hresp                              ),
        .boot_bus ( boot_bus                           ),
        .ram_bus  ( ram_bus                            ),
        .gpio_bus ( gpio_bus                           )
    );

    mfp_ahb_ram_slave #(
        .ADDR_WIDTH ( `MFP_BOOT_RAM_ADDR_WIDTH )
    ) boot_ram (
        .HCLK ( HCLK     ),
        .rst  ( rst      ),
        .bus  ( boot_bus )
    );

    mfp_ahb_ram_slave #(
        .ADDR_WIDTH ( `MFP_RAM_ADDR_WIDTH )
    ) ram (
        .HCLK ( HCLK    ),
        .rst  ( rst     ),
        .bus  ( ram_bus )
    );

    mfp_ahb_gpio_slave gpio (
        .HCLK             ( HCLK             ),
        .rst              ( rst              ),
        .bus              ( gpio_bus         ),
        .io_switches      ( io_switches      ),
        .io_buttons       ( io_buttons       ),
        .io_red_leds      ( io_red_leds      ),
        .io_green_leds    ( io_green_leds    ),
        .io_7_segment_hex ( io_7_segment_hex )
    );

endmodule

// ==== mfp_system.f ====
+incdir+include
logic/mfp_ahb_pkg.sv
logic/mfp_ahb_slave_if.sv
logic/mfp_ahb_lite_matrix.sv
logic/mfp_ahb_ram_slave.sv
logic/mfp_ahb_gpio_slave.sv
logic/mfp_system.sv
verif/mfp_system_tb.sv

// ==== verif/mfp_system_tb.sv ====
`timescale 1ns/10ps
`include "mfp_ahb_macros.svh"

module mfp_system_tb;

    localparam int R_BOOT = 0;
    localparam int R_RAM  = 1;
    localparam int R_GPIO = 2;
    localparam int R_NONE = 3;

    logic                                HCLK;
    logic                                rst;
    logic [31:0]                         haddr;
    logic [31:0]                         hwdata;
    logic [1:0]                          htrans;
    logic [2:0]                          hsize;
    logic                                hwrite;
    logic [31:0]                         hrdata;
    logic                                hready;
    logic                                hresp;
    logic [`MFP_N_SWITCHES-1:0]          io_switches;
    logic [`MFP_N_BUTTONS-1:0]           io_buttons;
    logic [`MFP_N_RED_LEDS-1:0]          io_red_leds;
    logic [`MFP_N_GREEN_LEDS-1:0]        io_green_leds;
    logic [`MFP_7_SEGMENT_HEX_WIDTH-1:0] io_7_segment_hex;

    // Model state
    logic [31:0]                         mem_model [logic [31:0]];
    logic [`MFP_N_RED_LEDS-1:0]          red_model;
    logic [`MFP_N_GREEN_LEDS-1:0]        green_model;
    logic [`MFP_7_SEGMENT_HEX_WIDTH-1:0] hex_model;
    logic [31:0]                         pool [$];

    // Transfer currently in its data phase
    logic [31:0] p_addr;
    logic [2:0]  p_size;
    logic [31:0] p_wdata;
    logic [31:0] p_data;
    logic        p_write;
    logic        p_err;
    logic        p_check;

    int checks;
    int errors;
    int checks_mark;
    int errors_mark;

    mfp_system i_dut (
        .HCLK             ( HCLK             ),
        .rst              ( rst              ),
        .haddr            ( haddr            ),
        .hwdata           ( hwdata           ),
        .htrans           ( htrans           ),
        .hsize            ( hsize            ),
        .hwrite           ( hwrite           ),
        .hrdata           ( hrdata           ),
        .hready           ( hready           ),
        .hresp            ( hresp            ),
        .io_switches      ( io_switches      ),
        .io_buttons       ( io_buttons       ),
        .io_red_leds      ( io_red_leds      ),
        .io_green_leds    ( io_green_leds    ),
        .io_7_segment_hex ( io_7_segment_hex )
    );

    initial HCLK = 1'b0;
    always #2 HCLK = ~HCLK;

    // ------------------------------
    // Address map and lanes as seen by the master
    function automatic int region_of(logic [31:0] a);
        if (a[28:22] == `MFP_BOOT_ADDR_MATCH)
            return R_BOOT;
        if (a[28] == `MFP_RAM_ADDR_MATCH)
            return R_RAM;
        if (a[28:22] == `MFP_GPIO_ADDR_MATCH)
            return R_GPIO;
        return R_NONE;
    endfunction

    function automatic logic [31:0] word_key(logic [31:0] a);
        if (region_of(a) == R_BOOT)
            return 32'h8000_0000 | ((a >> 2) & ((32'd1 << `MFP_BOOT_RAM_ADDR_WIDTH) - 1));
        return (a >> 2) & ((32'd1 << `MFP_RAM_ADDR_WIDTH) - 1);
    endfunction

    function automatic logic [3:0] lane_mask(logic [2:0] size, logic [1:0] low);
        case (size)
            mfp_ahb_pkg::BYTE: return 4'b0001 << low;
            mfp_ahb_pkg::HALF: return low[1] ? 4'b1100 : 4'b0011;
            default:           return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] boot_word(logic [31:0] r);
        return 32'h1FC0_0000 | ((r << 2) & ((32'd1 << (`MFP_BOOT_RAM_ADDR_WIDTH + 2)) - 32'd4));
    endfunction

    // Upper address bits stay random with bit 28 cleared
    function automatic logic [31:0] ram_word(logic [31:0] r);
        return (r << 2) & ~32'h1000_0003;
    endfunction

    function automatic logic [31:0] gpio_addr(logic [2:0] offset);
        return 32'h1F80_0000 | {27'd0, offset, 2'b00};
    endfunction

    function automatic logic [31:0] unmapped_addr(logic [31:0] r);
        logic [6:0] hi;
        hi = 7'h40 + r[27:22] % 6'd62;
        return {r[31:29], hi, r[21:2], 2'b00};
    endfunction

    function automatic logic [31:0] expected_read(logic [31:0] a);
        logic [31:0] v;
        v = '0;
        case (region_of(a))
            R_BOOT, R_RAM:
                v = mem_model.exists(word_key(a)) ? mem_model[word_key(a)] : 32'hxxxx_xxxx;
            R_GPIO:
                case (a[4:2])
                    `MFP_GPIO_RED_LEDS:      v[`MFP_N_RED_LEDS-1:0]          = red_model;
                    `MFP_GPIO_GREEN_LEDS:    v[`MFP_N_GREEN_LEDS-1:0]        = green_model;
                    `MFP_GPIO_7_SEGMENT_HEX: v[`MFP_7_SEGMENT_HEX_WIDTH-1:0] = hex_model;
                    `MFP_GPIO_SWITCHES:      v[`MFP_N_SWITCHES-1:0]          = io_switches;
                    `MFP_GPIO_BUTTONS:       v[`MFP_N_BUTTONS-1:0]           = io_buttons;
                    default:                 v = '0;
                endcase
            default:
                v = '0;
        endcase
        return v;
    endfunction

    // ------------------------------
    // Checking and reporting
    task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic end_test(string name);
        $display("Test %-12s %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    task automatic check_pins();
        check_eq("red LEDs", io_red_leds, red_model);
        check_eq("green LEDs", io_green_leds, green_model);
        check_eq("seven-segment", io_7_segment_hex, hex_model);
    endtask

    // ------------------------------
    // One call per address phase on the master side
    task automatic finish_data_phase();
        int waits;
        waits = 0;
        while (hready !== 1'b1 && waits < 16) begin
            check_eq("HRESP in wait cycle", hresp, 1'b1);
            @(posedge HCLK);
            @(negedge HCLK);
            waits++;
        end
        if (hready !== 1'b1) begin
            abort_run("Timeout: HREADY stayed low for 16 cycles");
        end else begin
            check_eq("wait cycles", waits, p_err ? 1 : 0);
            check_eq("HRESP", hresp, p_err);
            if (p_check)
                check_eq("HRDATA", hrdata, p_data);
        end
    endtask

    task automatic commit_write();
        logic [31:0] k;
        logic [31:0] w;
        logic [3:0]  lanes;
        if (!p_write)
            return;
        if (region_of(p_addr) == R_GPIO) begin
            case (p_addr[4:2])
                `MFP_GPIO_RED_LEDS:      red_model   = p_wdata[`MFP_N_RED_LEDS-1:0];
                `MFP_GPIO_GREEN_LEDS:    green_model = p_wdata[`MFP_N_GREEN_LEDS-1:0];
                `MFP_GPIO_7_SEGMENT_HEX: hex_model   = p_wdata[`MFP_7_SEGMENT_HEX_WIDTH-1:0];
                default:                 ;
            endcase
        end else begin
            k     = word_key(p_addr);
            w     = mem_model.exists(k) ? mem_model[k] : 32'hxxxx_xxxx;
            lanes = lane_mask(p_size, p_addr[1:0]);
            for (int i = 0; i < 4; i++) begin
                if (lanes[i])
                    w[8*i +: 8] = p_wdata[8*i +: 8];
            end
            mem_model[k] = w;
        end
    endtask

    task automatic bus_step(input logic [31:0] a, input logic [1:0] trans, input logic wr,
                            input logic [2:0] size, input logic [31:0] wdata);
        logic act;
        int   r;
        check_pins();
        haddr  = a;
        htrans = trans;
        hwrite = wr;
        hsize  = size;
        hwdata = p_wdata;
        finish_data_phase();
        @(posedge HCLK);
        // Write completes on this edge and the new address phase is taken
        commit_write();
        r       = region_of(a);
        act     = (trans == mfp_ahb_pkg::NONSEQ) || (trans == mfp_ahb_pkg::SEQ);
        p_addr  = a;
        p_size  = size;
        p_wdata = wdata;
        p_write = act && wr && (r != R_NONE);
        p_err   = act && (r == R_NONE);
        p_data  = expected_read(a);
        p_check = act && !wr && (r != R_NONE) && !$isunknown(p_data);
        @(negedge HCLK);
    endtask

    task automatic bus_idle();
        bus_step(32'h0, mfp_ahb_pkg::IDLE, 1'b0, mfp_ahb_pkg::WORD, 32'h0);
    endtask

    // ------------------------------
    // Tests
    task automatic test_ram_words();
        logic [31:0] a;
        pool.delete();
        for (int i = 0; i < 24; i++) begin
            a = (i % 2 == 0) ? boot_word($urandom) : ram_word($urandom);
            pool.push_back(a);
            bus_step(a, mfp_ahb_pkg::NONSEQ, 1'b1, mfp_ahb_pkg::WORD, $urandom);
        end
        for (int i = 0; i < 48; i++)
            bus_step(pool[$urandom % pool.size()], mfp_ahb_pkg::NONSEQ, 1'b0,
                     mfp_ahb_pkg::WORD, 32'h0);
        bus_idle();
        end_test("ram_words");
    endtask

    task automatic test_ram_lanes();
        logic [31:0] base;
        logic [31:0] rnd;
        logic [2:0]  size;
        for (int i = 0; i < 24; i++) begin
            rnd  = $urandom;
            base = pool[rnd[31:16] % pool.size()];
            size = rnd[0] ? mfp_ahb_pkg::HALF : mfp_ahb_pkg::BYTE;
            if (size == mfp_ahb_pkg::BYTE)
                base[1:0] = rnd[2:1];
            else
                base[1:0] = {rnd[1], 1'b0};
            bus_step(base, mfp_ahb_pkg::NONSEQ, 1'b1, size, $urandom);
            bus_step({base[31:2], 2'b00}, mfp_ahb_pkg::NONSEQ, 1'b0, mfp_ahb_pkg::WORD, 32'h0);
        end
        bus_idle();
        end_test("ram_lanes");
    endtask

    task automatic test_gpio();
        logic [31:0] rnd;
        for (int i = 0; i < 4; i++) begin
            rnd         = $urandom;
            io_switches = rnd[`MFP_N_SWITCHES-1:0];
            io_buttons  = rnd[31:32-`MFP_N_BUTTONS];
            for (int off = 0; off < 8; off++)
                bus_step(gpio_addr(off), mfp_ahb_pkg::NONSEQ, 1'b1, mfp_ahb_pkg::WORD, $urandom);
            for (int off = 0; off < 8; off++)
                bus_step(gpio_addr(off), mfp_ahb_pkg::NONSEQ, 1'b0, mfp_ahb_pkg::WORD, 32'h0);
        end
        bus_idle();
        end_test("gpio");
    endtask

    task automatic test_unmapped();
        logic [31:0] rnd;
        for (int i = 0; i < 8; i++) begin
            rnd = $urandom;
            bus_step(unmapped_addr($urandom), mfp_ahb_pkg::NONSEQ, rnd[0],
                     mfp_ahb_pkg::WORD, $urandom);
            bus_step(pool[rnd[31:16] % pool.size()], mfp_ahb_pkg::NONSEQ, 1'b0,
                     mfp_ahb_pkg::WORD, 32'h0);
            bus_step(gpio_addr(rnd[2:1]), mfp_ahb_pkg::NONSEQ, 1'b0, mfp_ahb_pkg::WORD, 32'h0);
        end
        bus_idle();
        end_test("unmapped");
    endtask

    task automatic test_stream();
        logic [31:0] a;
        logic [31:0] rnd;
        logic [31:0] last_addr;
        logic [2:0]  size;
        logic        last_wr;
        int          pick;
        last_wr   = 1'b0;
        last_addr = '0;
        for (int n = 0; n < 400; n++) begin
            rnd  = $urandom;
            pick = rnd[3:0];
            if (rnd[4]) begin
                io_switches = rnd[31:32-`MFP_N_SWITCHES];
                io_buttons  = rnd[8:5];
            end
            if (last_wr && pick < 5) begin
                // Same word straight after its write
                bus_step({last_addr[31:2], 2'b00}, mfp_ahb_pkg::SEQ, 1'b0,
                         mfp_ahb_pkg::WORD, 32'h0);
                last_wr = 1'b0;
            end else if (pick < 8) begin
                // Idle and busy cycles leave every target untouched
                if (rnd[12:11] == 2'd0)
                    a = unmapped_addr($urandom);
                else if (rnd[12:11] == 2'd1)
                    a = gpio_addr(rnd[15:13]);
                else
                    a = pool[rnd[31:16] % pool.size()];
                bus_step(a, rnd[5] ? mfp_ahb_pkg::BUSY : mfp_ahb_pkg::IDLE,
                         rnd[6], mfp_ahb_pkg::WORD, $urandom);
                last_wr = 1'b0;
            end else if (pick == 8) begin
                bus_step(unmapped_addr($urandom), mfp_ahb_pkg::NONSEQ, rnd[6],
                         mfp_ahb_pkg::WORD, $urandom);
                last_wr = 1'b0;
            end else begin
                if (pick > 13) begin
                    a    = gpio_addr(rnd[13:11]);
                    size = mfp_ahb_pkg::WORD;
                end else begin
                    a = pool[rnd[31:16] % pool.size()];
                    if (rnd[10:9] == 2'd0) begin
                        size    = mfp_ahb_pkg::BYTE;
                        a[1:0]  = rnd[12:11];
                    end else if (rnd[10:9] == 2'd1) begin
                        size    = mfp_ahb_pkg::HALF;
                        a[1:0]  = {rnd[12], 1'b0};
                    end else begin
                        size    = mfp_ahb_pkg::WORD;
                    end
                end
                bus_step(a, rnd[7] ? mfp_ahb_pkg::SEQ : mfp_ahb_pkg::NONSEQ, rnd[6], size,
                         $urandom);
                last_wr   = rnd[6];
                last_addr = a;
            end
        end
        bus_idle();
        end_test("stream");
    endtask

    // ------------------------------
    initial begin
        void'($urandom(69));
        rst         = 1'b1;
        haddr       = '0;
        hwdata      = '0;
        htrans      = mfp_ahb_pkg::IDLE;
        hsize       = mfp_ahb_pkg::WORD;
        hwrite      = 1'b0;
        io_switches = '0;
        io_buttons  = '0;
        red_model   = '0;
        green_model = '0;
        hex_model   = '0;
        p_addr      = '0;
        p_size      = mfp_ahb_pkg::WORD;
        p_wdata     = '0;
        p_data      = '0;
        p_write     = 1'b0;
        p_err       = 1'b0;
        p_check     = 1'b0;
        checks      = 0;
        errors      = 0;
        checks_mark = 0;
        errors_mark = 0;

        repeat (10) @(posedge HCLK);
        @(negedge HCLK);
        rst = 1'b0;
        @(negedge HCLK);
        check_eq("HREADY after reset", hready, 1'b1);
        check_eq("HRESP after reset", hresp, 1'b0);
        check_pins();
        end_test("reset");

        test_ram_words();
        test_ram_lanes();
        test_gpio();
        test_unmapped();
        test_stream();

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
